// ==== all.f ====
hw/flr_bus_pkg.sv
hw/pfvf_route_pkg.sv
hw/flr_if.sv
hw/flr_req_route.sv
hw/flr_rsp_fifo.sv
hw/rr_arbiter.sv
hw/flr_rsp_merge.sv
hw/flr_mux_top.sv
verif/tb_clk_gen.sv
verif/tb_flr_mux.sv

// ==== hw/flr_bus_pkg.sv ====
// FLR bus field widths, FLR function payload type and default agent port count
`default_nettype none

package flr_bus_pkg;

   // ----------------------------------------
   // Field widths
   // ----------------------------------------
   localparam int PF_WIDTH = 3;
   localparam int VF_WIDTH = 11;

   // Default number of agent ports behind the host
   localparam int NUM_PORT_DEFAULT = 4;

   // ----------------------------------------
   // FLR payload
   // ----------------------------------------

   // Function under reset, as carried on host and agent FLR buses
   typedef struct packed {
      logic [PF_WIDTH-1:0] pf;
      logic [VF_WIDTH-1:0] vf;
      logic                vf_active;
   } t_flr_func;

endpackage : flr_bus_pkg

`default_nettype wire

// ==== hw/flr_if.sv ====
// FLR strobe interface with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface flr_if
   import flr_bus_pkg::*;
();

   // One event per cycle with valid high, no ready
   logic                valid;
   logic [PF_WIDTH-1:0] pf;
   logic [VF_WIDTH-1:0] vf;
   logic                vf_active;

   modport source (
      output valid, pf, vf, vf_active
   );

   modport sink (
      input valid, pf, vf, vf_active
   );

endinterface : flr_if

`default_nettype wire

// ==== hw/flr_mux_top.sv ====
// FLR mux top level, host and agent FLR buses as plain ports
`timescale 1ns/1ps
`default_nettype none

module flr_mux_top
   import flr_bus_pkg::*;
   import pfvf_route_pkg::*;
#(
   parameter int NUM_PORT = NUM_PORT_DEFAULT,
   parameter int NUM_ROUTE_ENTRIES = NUM_ROUTE_ENTRIES_DEFAULT,
   parameter t_route_entry [NUM_ROUTE_ENTRIES-1:0] ROUTE_TABLE = ROUTE_TABLE_DEFAULT
) (
   input  wire logic                               clk,
   input  wire logic                               rst,
   // Host request
   input  wire logic                               h_req_valid,
   input  wire logic [PF_WIDTH-1:0]                h_req_pf,
   input  wire logic [VF_WIDTH-1:0]                h_req_vf,
   input  wire logic                               h_req_vf_active,
   // Host response
   output logic                                    h_rsp_valid,
   output logic      [PF_WIDTH-1:0]                h_rsp_pf,
   output logic      [VF_WIDTH-1:0]                h_rsp_vf,
   output logic                                    h_rsp_vf_active,
   // Agent requests, one slot per port
   output logic      [NUM_PORT-1:0]                a_req_valid,
   output logic      [NUM_PORT-1:0][PF_WIDTH-1:0]  a_req_pf,
   output logic      [NUM_PORT-1:0][VF_WIDTH-1:0]  a_req_vf,
   output logic      [NUM_PORT-1:0]                a_req_vf_active,
   // Agent responses
   input  wire logic [NUM_PORT-1:0]                a_rsp_valid,
   input  wire logic [NUM_PORT-1:0][PF_WIDTH-1:0]  a_rsp_pf,
   input  wire logic [NUM_PORT-1:0][VF_WIDTH-1:0]  a_rsp_vf,
   input  wire logic [NUM_PORT-1:0]                a_rsp_vf_active
);

   flr_if h_req_bus ();
   flr_if h_rsp_bus ();
   flr_if a_req_bus [NUM_PORT] ();
   flr_if a_rsp_bus [NUM_PORT] ();

   // ----------------------------------------
   // Host side
   // ----------------------------------------
   assign h_req_bus.valid     = h_req_valid;
   assign h_req_bus.pf        = h_req_pf;
   assign h_req_bus.vf        = h_req_vf;
   assign h_req_bus.vf_active = h_req_vf_active;

   assign h_rsp_valid     = h_rsp_bus.valid;
   assign h_rsp_pf        = h_rsp_bus.pf;
   assign h_rsp_vf        = h_rsp_bus.vf;
   assign h_rsp_vf_active = h_rsp_bus.vf_active;

   // ----------------------------------------
   // Agent side
   // ----------------------------------------
   for (genvar p = 0; p < NUM_PORT; p++) begin : g_agent
      assign a_req_valid[p]     = a_req_bus[p].valid;
      assign a_req_pf[p]        = a_req_bus[p].pf;
      assign a_req_vf[p]        = a_req_bus[p].vf;
      assign a_req_vf_active[p] = a_req_bus[p].vf_active;

      assign a_rsp_bus[p].valid     = a_rsp_valid[p];
      assign a_rsp_bus[p].pf        = a_rsp_pf[p];
      assign a_rsp_bus[p].vf        = a_rsp_vf[p];
      assign a_rsp_bus[p].vf_active = a_rsp_vf_active[p];
   end : g_agent

   // Request and response paths run independently
   flr_req_route #(
      .NUM_PORT          (NUM_PORT),
      .NUM_ROUTE_ENTRIES (NUM_ROUTE_ENTRIES),
      .ROUTE_TABLE       (ROUTE_TABLE)
   ) u_req_route (
      .clk       (clk),
      .rst       (rst),
      .host_req  (h_req_bus),
      .agent_req (a_req_bus)
   );

   flr_rsp_merge #(
      .NUM_PORT (NUM_PORT)
   ) u_rsp_merge (
      .clk       (clk),
      .rst       (rst),
      .agent_rsp (a_rsp_bus),
      .host_rsp  (h_rsp_bus)
   );

endmodule : flr_mux_top

`default_nettype wire

// ==== hw/flr_req_route.sv ====
// Registered host to agent FLR request demultiplexer using the routing table
`timescale 1ns/1ps
`default_nettype none

module flr_req_route
   import flr_bus_pkg::*;
   import pfvf_route_pkg::*;
#(
   parameter int NUM_PORT = NUM_PORT_DEFAULT,
   parameter int NUM_ROUTE_ENTRIES = NUM_ROUTE_ENTRIES_DEFAULT,
   parameter t_route_entry [NUM_ROUTE_ENTRIES-1:0] ROUTE_TABLE = ROUTE_TABLE_DEFAULT
) (
   input  wire logic clk,
   input  wire logic rst,
   flr_if.sink       host_req,
   flr_if.source     agent_req [NUM_PORT]
);

   t_flr_func             req_func;
   logic                  route_hit;
   logic [PORT_WIDTH-1:0] route_port;

   assign req_func = '{pf: host_req.pf, vf: host_req.vf, vf_active: host_req.vf_active};

   // First matching entry wins
   always_comb begin : route_search
      route_hit  = 1'b0;
      route_port = '0;
      for (int i = 0; i < NUM_ROUTE_ENTRIES; i++) begin
         if (!route_hit && pfvf_route_match(req_func, ROUTE_TABLE[i])) begin
            route_hit  = 1'b1;
            route_port = ROUTE_TABLE[i].port;
         end
      end
   end : route_search

   for (genvar p = 0; p < NUM_PORT; p++) begin : g_port
      // Only the chosen port sees valid; unmatched requests vanish
      always_ff @(posedge clk) begin
         if (rst) begin
            agent_req[p].valid <= 1'b0;
         end else begin
            agent_req[p].valid <= host_req.valid && route_hit &&
                                  (route_port == PORT_WIDTH'(p));
         end
      end

      always_ff @(posedge clk) begin
         agent_req[p].pf        <= host_req.pf;
         agent_req[p].vf        <= host_req.vf;
         agent_req[p].vf_active <= host_req.vf_active;
      end
   end : g_port

endmodule : flr_req_route

`default_nettype wire

// ==== hw/flr_rsp_fifo.sv ====
// Synchronous FIFO for agent FLR responses, read latency of one cycle
`timescale 1ns/1ps
`default_nettype none

module flr_rsp_fifo
   import flr_bus_pkg::*;
#(
   parameter int DEPTH_LOG2 = 2
) (
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire logic      wr_en,
   input  wire t_flr_func wr_data,
   input  wire logic      rd_en,
   output logic           empty,
   output logic           rd_valid,
   output t_flr_func      rd_data
);

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   t_flr_func             mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  rd_fire;

   assign empty   = (count == '0);
   // A read of an empty FIFO is ignored
   assign rd_fire = rd_en && !empty;

   // ----------------------------------------
   // Storage
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_fire) begin
         rd_data <= mem[rd_ptr];
      end
   end

   // ----------------------------------------
   // Pointers and fill level
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_fire;
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule : flr_rsp_fifo

`default_nettype wire

// ==== hw/flr_rsp_merge.sv ====
// Per-port FLR response FIFOs and round-robin merge onto the host response bus
`timescale 1ns/1ps
`default_nettype none

module flr_rsp_merge
   import flr_bus_pkg::*;
#(
   parameter int NUM_PORT = NUM_PORT_DEFAULT
) (
   input  wire logic clk,
   input  wire logic rst,
   flr_if.sink       agent_rsp [NUM_PORT],
   flr_if.source     host_rsp
);

   // Holds NUM_PORT entries, enough for a port to wait behind all others
   localparam int DEPTH_LOG2 = (NUM_PORT > 1) ? $clog2(NUM_PORT) : 1;
   localparam int SEL_WIDTH  = (NUM_PORT > 1) ? $clog2(NUM_PORT) : 1;

   t_flr_func            port_wr_data [NUM_PORT];
   t_flr_func            port_rd_data [NUM_PORT];
   logic [NUM_PORT-1:0]  port_rd_valid;
   logic [NUM_PORT-1:0]  port_empty;
   logic [NUM_PORT-1:0]  arb_gnt;
   logic [SEL_WIDTH-1:0] arb_idx;
   logic                 arb_valid;
   logic [SEL_WIDTH-1:0] sel_q;

   // ----------------------------------------
   // Response buffers
   // ----------------------------------------
   for (genvar p = 0; p < NUM_PORT; p++) begin : g_port
      assign port_wr_data[p] = '{
         pf:        agent_rsp[p].pf,
         vf:        agent_rsp[p].vf,
         vf_active: agent_rsp[p].vf_active
      };

      flr_rsp_fifo #(
         .DEPTH_LOG2(DEPTH_LOG2)
      ) u_fifo (
         .clk      (clk),
         .rst      (rst),
         .wr_en    (agent_rsp[p].valid),
         .wr_data  (port_wr_data[p]),
         .rd_en    (arb_gnt[p] && arb_valid),
         .empty    (port_empty[p]),
         .rd_valid (port_rd_valid[p]),
         .rd_data  (port_rd_data[p])
      );
   end : g_port

   rr_arbiter #(
      .NUM_INPUTS(NUM_PORT)
   ) u_arb (
      .clk        (clk),
      .rst        (rst),
      .req        (~port_empty),
      .gnt_onehot (arb_gnt),
      .gnt_idx    (arb_idx),
      .gnt_valid  (arb_valid)
   );

   // ----------------------------------------
   // Output select and register
   // ----------------------------------------

   // Select lags grant by the FIFO read latency
   always_ff @(posedge clk) begin
      if (rst) begin
         sel_q          <= '0;
         host_rsp.valid <= 1'b0;
      end else begin
         sel_q          <= arb_idx;
         host_rsp.valid <= port_rd_valid[sel_q];
      end
   end

   always_ff @(posedge clk) begin
      host_rsp.pf        <= port_rd_data[sel_q].pf;
      host_rsp.vf        <= port_rd_data[sel_q].vf;
      host_rsp.vf_active <= port_rd_data[sel_q].vf_active;
   end

endmodule : flr_rsp_merge

`default_nettype wire

// ==== hw/pfvf_route_pkg.sv ====
// Routing table entry type, table match function and default routing table
`default_nettype none

package pfvf_route_pkg;

   import flr_bus_pkg::*;

   localparam int PORT_WIDTH = 4;

   // One routing rule; pf_any and vf_any turn the field into a wildcard
   typedef struct packed {
      logic [PF_WIDTH-1:0]   pf;
      logic [VF_WIDTH-1:0]   vf;
      logic                  vf_active;
      logic                  pf_any;
      logic                  vf_any;
      logic [PORT_WIDTH-1:0] port;
   } t_route_entry;

   // True when the function falls under the entry
   function automatic logic pfvf_route_match(input t_flr_func func, input t_route_entry entry);
      logic pf_ok;
      logic vf_ok;
      pf_ok = entry.pf_any || (func.pf == entry.pf);
      // vf only counts for VF resets
      vf_ok = !func.vf_active || entry.vf_any || (func.vf == entry.vf);
      return pf_ok && (func.vf_active == entry.vf_active) && vf_ok;
   endfunction : pfvf_route_match

   // ----------------------------------------
   // Default table, index 0 searched first
   // ----------------------------------------
   localparam int NUM_ROUTE_ENTRIES_DEFAULT = 4;

   localparam t_route_entry [NUM_ROUTE_ENTRIES_DEFAULT-1:0] ROUTE_TABLE_DEFAULT = '{
      // Catch-all for PF resets
      3: '{pf: '0, vf: '0, vf_active: 1'b0, pf_any: 1'b1, vf_any: 1'b1, port: 4'd0},
      // PF 2 itself
      2: '{pf: 3'd2, vf: '0, vf_active: 1'b0, pf_any: 1'b0, vf_any: 1'b0, port: 4'd3},
      // Every VF of PF 1
      1: '{pf: 3'd1, vf: '0, vf_active: 1'b1, pf_any: 1'b0, vf_any: 1'b1, port: 4'd2},
      // Every VF of PF 0
      0: '{pf: 3'd0, vf: '0, vf_active: 1'b1, pf_any: 1'b0, vf_any: 1'b1, port: 4'd1}
   };

endpackage : pfvf_route_pkg

`default_nettype wire

// ==== hw/rr_arbiter.sv ====
// Fair round-robin arbiter with one-hot and index grant outputs
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
   parameter int NUM_INPUTS = 4,
   localparam int IDX_WIDTH = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
) (
   input  wire logic [NUM_INPUTS-1:0] req,
   input  wire logic                  clk,
   input  wire logic                  rst,
   output logic      [NUM_INPUTS-1:0] gnt_onehot,
   output logic      [IDX_WIDTH-1:0]  gnt_idx,
   output logic                       gnt_valid
);

   // Highest priority input for the current cycle
   logic [IDX_WIDTH-1:0] ptr;

   always_comb begin : grant_search
      int idx;
      gnt_onehot = '0;
      gnt_idx    = '0;
      gnt_valid  = 1'b0;
      // Walk from the pointer, wrapping at the top
      for (int i = 0; i < NUM_INPUTS; i++) begin
         idx = (int'(ptr) + i) % NUM_INPUTS;
         if (!gnt_valid && req[idx]) begin
            gnt_valid       = 1'b1;
            gnt_idx         = IDX_WIDTH'(idx);
            gnt_onehot[idx] = 1'b1;
         end
      end
   end : grant_search

   // Winner drops to lowest priority
   always_ff @(posedge clk) begin
      if (rst) begin
         ptr <= '0;
      end else if (gnt_valid) begin
         if (int'(gnt_idx) == NUM_INPUTS - 1) begin
            ptr <= '0;
         end else begin
            ptr <= gnt_idx + 1'b1;
         end
      end
   end

endmodule : rr_arbiter

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Testbench clock source and power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 10,
   parameter int RST_CYCLES = 5
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset drops on a falling edge, like every other DUT input
   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule : tb_clk_gen

`default_nettype wire

// ==== verif/tb_flr_mux.sv ====
// FLR mux testbench with request routing reference, response scoreboards and checks
`timescale 1ns/1ps
`default_nettype none

module tb_flr_mux
   import flr_bus_pkg::*;
   import pfvf_route_pkg::*;
();

   localparam int N              = NUM_PORT_DEFAULT;
   localparam int RND_CYCLES     = 200;
   localparam int TRAFFIC_CYCLES = 300;
   localparam int DRAIN_CYCLES   = N * N + 8;
   localparam int STIM_CYCLES    = 8 + 13 + RND_CYCLES + 2 + (N + 2) * DRAIN_CYCLES
                                   + TRAFFIC_CYCLES;
   localparam int CYCLE_LIMIT    = STIM_CYCLES + 3 * N + 20;

   logic                       clk;
   logic                       rst;
   logic                       h_req_valid;
   t_flr_func                  h_req;
   logic                       h_rsp_valid;
   logic [PF_WIDTH-1:0]        h_rsp_pf;
   logic [VF_WIDTH-1:0]        h_rsp_vf;
   logic                       h_rsp_vf_active;
   logic [N-1:0]               a_req_valid;
   logic [N-1:0][PF_WIDTH-1:0] a_req_pf;
   logic [N-1:0][VF_WIDTH-1:0] a_req_vf;
   logic [N-1:0]               a_req_vf_active;
   logic [N-1:0]               a_rsp_valid;
   logic [N-1:0][PF_WIDTH-1:0] a_rsp_pf;
   logic [N-1:0][VF_WIDTH-1:0] a_rsp_vf;
   logic [N-1:0]               a_rsp_vf_active;

   // Scoreboard state
   t_flr_func rsp_q [N][$];
   int        order_q [$];
   int        rsp_sent [N];
   int        rsp_rcvd [N];
   int        host_cnt = 0;
   int        agent_cnt = 0;
   int        err_cnt = 0;
   int        err_start = 0;
   int        test_cnt = 0;
   int        fail_cnt = 0;
   int        cycle_cnt = 0;
   string     cur_test = "reset";
   logic      edge_live = 1'b0;
   logic      req_seen = 1'b0;
   t_flr_func req_func = '0;

   tb_clk_gen #(
      .PERIOD_NS  (10),
      .RST_CYCLES (5)
   ) u_clk_gen (
      .clk (clk),
      .rst (rst)
   );

   flr_mux_top u_flr_mux_top (
      .clk             (clk),
      .rst             (rst),
      .h_req_valid     (h_req_valid),
      .h_req_pf        (h_req.pf),
      .h_req_vf        (h_req.vf),
      .h_req_vf_active (h_req.vf_active),
      .h_rsp_valid     (h_rsp_valid),
      .h_rsp_pf        (h_rsp_pf),
      .h_rsp_vf        (h_rsp_vf),
      .h_rsp_vf_active (h_rsp_vf_active),
      .a_req_valid     (a_req_valid),
      .a_req_pf        (a_req_pf),
      .a_req_vf        (a_req_vf),
      .a_req_vf_active (a_req_vf_active),
      .a_rsp_valid     (a_rsp_valid),
      .a_rsp_pf        (a_rsp_pf),
      .a_rsp_vf        (a_rsp_vf),
      .a_rsp_vf_active (a_rsp_vf_active)
   );

   // ----------------------------------------
   // Reference model and compare tasks
   // ----------------------------------------

   // Expected agent port or -1 when no table entry takes the request
   function automatic int ref_route(input t_flr_func f);
      t_route_entry e;
      for (int i = 0; i < NUM_ROUTE_ENTRIES_DEFAULT; i++) begin
         e = ROUTE_TABLE_DEFAULT[i];
         if ((e.pf_any || e.pf == f.pf) && e.vf_active == f.vf_active &&
             (!f.vf_active || e.vf_any || e.vf == f.vf)) begin
            return int'(e.port);
         end
      end
      return -1;
   endfunction

   function automatic string func_str(input t_flr_func f);
      return $sformatf("pf %0d vf %0d vf_active %0b", f.pf, f.vf, f.vf_active);
   endfunction

   task automatic check_req(input t_flr_func exp, input int exp_port);
      logic [N-1:0] exp_mask;
      t_flr_func    act;
      exp_mask = '0;
      if (exp_port >= 0 && exp_port < N) begin
         exp_mask[exp_port] = 1'b1;
      end
      if (a_req_valid !== exp_mask) begin
         err_cnt++;
         $display("mismatch %s: agent request strobes expected %b actual %b",
                  cur_test, exp_mask, a_req_valid);
      end else if (exp_mask != '0) begin
         act = '{pf: a_req_pf[exp_port], vf: a_req_vf[exp_port],
                 vf_active: a_req_vf_active[exp_port]};
         if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s: port %0d request expected %s actual %s",
                     cur_test, exp_port, func_str(exp), func_str(act));
         end
      end
   endtask

   task automatic check_rsp(input t_flr_func exp, input t_flr_func act);
      if (act !== exp) begin
         err_cnt++;
         $display("mismatch %s: host response expected %s actual %s",
                  cur_test, func_str(exp), func_str(act));
      end
   endtask

   // ----------------------------------------
   // Monitors
   // ----------------------------------------

   // Inputs are stable at the rising edge
   always @(posedge clk) begin : capture_inputs
      edge_live = !rst;
      req_seen  = h_req_valid && !rst;
      req_func  = h_req;
      for (int p = 0; p < N; p++) begin
         if (!rst && a_rsp_valid[p]) begin
            rsp_q[p].push_back('{pf: a_rsp_pf[p], vf: a_rsp_vf[p],
                                 vf_active: a_rsp_vf_active[p]});
            agent_cnt++;
         end
      end
   end

   // Registered outputs settle by the falling edge
   always @(negedge clk) begin : compare_outputs
      t_flr_func act;
      t_flr_func exp;
      int        src;
      int        exp_src;
      if (edge_live) begin
         check_req(req_func, req_seen ? ref_route(req_func) : -1);
         if (h_rsp_valid) begin
            act = '{pf: h_rsp_pf, vf: h_rsp_vf, vf_active: h_rsp_vf_active};
            src = int'(act.pf);   // stimulus tags each response with its port
            host_cnt++;
            if (src >= N || rsp_q[src].size() == 0) begin
               err_cnt++;
               $display("error %s: host response %s has no outstanding agent response",
                        cur_test, func_str(act));
            end else begin
               if (order_q.size() != 0) begin
                  exp_src = order_q.pop_front();
                  if (exp_src != src) begin
                     err_cnt++;
                     $display("mismatch %s: grant order expected port %0d actual port %0d",
                              cur_test, exp_src, src);
                  end
               end
               exp = rsp_q[src].pop_front();
               check_rsp(exp, act);
               rsp_rcvd[src]++;
            end
         end
      end
   end

   always @(posedge clk) begin : timeout_watch
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // ----------------------------------------
   // Stimulus helpers
   // ----------------------------------------
   task automatic begin_test(input string name);
      cur_test  = name;
      err_start = err_cnt;
   endtask

   task automatic end_test();
      int errs;
      if (host_cnt != agent_cnt) begin
         err_cnt++;
         $display("mismatch %s: host response count expected %0d actual %0d",
                  cur_test, agent_cnt, host_cnt);
      end
      if (order_q.size() != 0) begin
         err_cnt++;
         $display("error %s: %0d round-robin grants never reached the host",
                  cur_test, order_q.size());
         order_q.delete();
      end
      errs = err_cnt - err_start;
      test_cnt++;
      if (errs != 0) begin
         fail_cnt++;
      end
      $display("test %s: %s, %0d errors", cur_test, (errs == 0) ? "ok" : "failed", errs);
   endtask

   task automatic idle(input int cycles);
      h_req_valid = 1'b0;
      a_rsp_valid = '0;
      repeat (cycles) @(negedge clk);
   endtask

   // Drives one request cycle; exp_port is worked out by hand from the table
   task automatic send_req(input int pf, input int vf, input logic vfa, input int exp_port);
      h_req       = '{pf: PF_WIDTH'(pf), vf: VF_WIDTH'(vf), vf_active: vfa};
      h_req_valid = 1'b1;
      if (ref_route(h_req) != exp_port) begin
         err_cnt++;
         $display("mismatch %s: route of %s expected port %0d actual %0d",
                  cur_test, func_str(h_req), exp_port, ref_route(h_req));
      end
      @(negedge clk);
   endtask

   // Random fields per port with pf carrying the port number
   task automatic set_rsp(input logic [N-1:0] mask);
      t_flr_func f;
      for (int p = 0; p < N; p++) begin
         f                  = t_flr_func'($urandom);
         a_rsp_pf[p]        = PF_WIDTH'(p);
         a_rsp_vf[p]        = f.vf;
         a_rsp_vf_active[p] = f.vf_active;
         if (mask[p]) begin
            rsp_sent[p]++;
         end
      end
      a_rsp_valid = mask;
   endtask

   function automatic logic rsp_pending();
      for (int p = 0; p < N; p++) begin
         if (rsp_q[p].size() != 0) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   // Queues only shrink on falling edges, so poll on rising ones
   task automatic wait_drain();
      @(posedge clk);
      while (rsp_pending()) begin
         @(posedge clk);
      end
      @(negedge clk);
      idle(4);
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin : run_tests
      logic [N-1:0] mask;
      int           rr_next;
      void'($urandom(4894));
      h_req_valid     = 1'b0;
      h_req           = '0;
      a_rsp_valid     = '0;
      a_rsp_pf        = '0;
      a_rsp_vf        = '0;
      a_rsp_vf_active = '0;
      rr_next         = 0;
      @(negedge rst);
      @(negedge clk);

      begin_test("directed_requests");
      send_req(0, 5, 1'b1, 1);
      send_req(0, 2047, 1'b1, 1);
      send_req(1, 0, 1'b1, 2);
      send_req(1, 100, 1'b1, 2);
      send_req(2, 0, 1'b0, 3);
      send_req(2, 33, 1'b0, 3);
      send_req(0, 0, 1'b0, 0);
      send_req(7, 9, 1'b0, 0);
      send_req(1, 0, 1'b0, 0);
      send_req(3, 1, 1'b1, -1);
      send_req(2, 4, 1'b1, -1);
      idle(2);
      end_test();

      begin_test("random_requests");
      repeat (RND_CYCLES) begin
         h_req       = t_flr_func'($urandom);
         h_req_valid = ($urandom_range(3, 0) != 0);
         @(negedge clk);
      end
      idle(2);
      end_test();

      // Highest port first, so the arbiter pointer ends up off port 0
      begin_test("single_responses");
      for (int p = N - 1; p >= 0; p--) begin
         set_rsp(N'(1) << p);
         @(negedge clk);
         idle(0);
         wait_drain();
         rr_next = (p + 1) % N;
      end
      end_test();

      begin_test("simultaneous_responses");
      for (int i = 0; i < N; i++) begin
         order_q.push_back((rr_next + i) % N);
      end
      set_rsp('1);
      @(negedge clk);
      idle(0);
      wait_drain();
      end_test();

      begin_test("random_responses");
      for (int c = 0; c < TRAFFIC_CYCLES; c++) begin
         @(posedge clk);
         for (int p = 0; p < N; p++) begin
            mask[p] = ($urandom_range(1, 0) == 1) && (rsp_sent[p] - rsp_rcvd[p] < N);
         end
         @(negedge clk);
         set_rsp(mask);
      end
      @(negedge clk);
      idle(0);
      wait_drain();
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule : tb_flr_mux

`default_nettype wire
